// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_snes_mcu_bridge
FILELIST  ?= snes_mcu_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN) snes_mcu_bridge_testdata.txt
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bridge_checker.sv
`timescale 1ns/100ps

module bridge_checker
  import snes_bus_pkg::*;
  import mem_access_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // DUT ports under watch
  input  mcu_req_t  mcu_req,
  input  logic      mcu_rdy,
  input  byte_t     mcu_din,
  input  byte_t     snes_data_out,
  input  logic      snes_databus_oe,
  input  logic      snes_reset_strobe,
  input  rom_port_t rom,
  // Check requests from the testbench, one cycle each
  input  logic      chk_reset,
  input  logic      chk_din,
  input  logic      chk_lat,
  input  logic      chk_console,
  input  logic      chk_strobes,
  input  byte_t     exp_value,
  output int        errors
);

  int lat_cnt;
  int last_lat;    // Strobe to ready, last completed access
  int strobe_cnt;  // Reset pulses since the last count check
  bit timing;

  initial errors = 0;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, want, got, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sampling mid-cycle, away from both edges of DUT activity
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!rst_n) begin
      timing     = 1'b0;
      lat_cnt    = 0;
      last_lat   = 0;
      strobe_cnt = 0;
    end else begin
      if (timing) begin
        lat_cnt = lat_cnt + 1;
        if (mcu_rdy) begin
          timing   = 1'b0;
          last_lat = lat_cnt;
        end
      end else if (mcu_rdy && (mcu_req.rrq || mcu_req.wrq)) begin
        timing  = 1'b1;  // Accepted request
        lat_cnt = 0;
      end
      if (snes_reset_strobe) strobe_cnt = strobe_cnt + 1;

      if (chk_reset) begin
        compare_value("mcu_rdy", 32'(mcu_rdy), 32'd1);
        compare_value("rom.we_n", 32'(rom.we_n), 32'd1);
        compare_value("rom.data_oe", 32'(rom.data_oe), 32'd0);
        compare_value("snes_databus_oe", 32'(snes_databus_oe), 32'd1);
        compare_value("snes_reset_strobe", 32'(snes_reset_strobe), 32'd0);
      end
      if (chk_din) compare_value("mcu_din", 32'(mcu_din), 32'(exp_value));
      if (chk_lat) compare_value("mcu_rdy latency", 32'(last_lat), 32'(exp_value));
      if (chk_console) begin
        compare_value("snes_data_out", 32'(snes_data_out), 32'(exp_value));
        compare_value("snes_databus_oe", 32'(snes_databus_oe), 32'd0);
      end
      if (chk_strobes) begin
        compare_value("snes_reset_strobe count", 32'(strobe_cnt), 32'(exp_value));
        strobe_cnt = 0;
      end
    end
  end

endmodule

// File: mem_access_pkg.sv
`include "snes_mcu_bridge_consts.svh"

package mem_access_pkg;

  typedef logic [`ROM_WORD_W-1:0] rom_word_t;
  typedef logic [`ROM_DATA_W-1:0] rom_data_t;

  // One-cycle MCU request strobe with its payload
  typedef struct packed {
    logic                    rrq;
    logic                    wrq;
    snes_bus_pkg::snes_addr_t addr;   // Byte address
    snes_bus_pkg::byte_t      wdata;
  } mcu_req_t;

  typedef enum logic [4:0] {
    ST_IDLE        = 5'b00001,
    ST_MCU_RD_ADDR = 5'b00010,
    ST_MCU_RD_END  = 5'b00100,
    ST_MCU_WR_ADDR = 5'b01000,
    ST_MCU_WR_END  = 5'b10000
  } arb_state_t;

  // ROM/PSRAM pins, strobes active low
  typedef struct packed {
    rom_word_t addr;
    rom_data_t wdata;
    logic      data_oe;
    logic      we_n;
    logic      bhe_n;
    logic      ble_n;
  } rom_port_t;

endpackage

// File: rom_arbiter_fsm.sv
`timescale 1ns/100ps
`include "snes_mcu_bridge_consts.svh"

module rom_arbiter_fsm
  import snes_bus_pkg::*;
  import mem_access_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  mcu_req_t   mcu_req,
  input  snes_evt_t  evt,
  input  logic       snes_dead,
  input  logic       cpu_clk_level,
  output arb_state_t state,
  output snes_addr_t mcu_addr_q,
  output byte_t      mcu_wdata_q,
  output logic       mcu_rdy
);

  localparam int DLY_W = $clog2(`ROM_CYCLE_LEN + 1);
  localparam logic [DLY_W-1:0] DLY_RELOAD = DLY_W'(`ROM_CYCLE_LEN);

  logic             rd_pend;
  logic             wr_pend;
  logic [DLY_W-1:0] delay_q;
  logic             req_ok;
  logic             access_done;
  logic             wake_abort;
  logic             slot_ok;
  logic             in_addr;

  assign req_ok      = mcu_rdy & (mcu_req.rrq | mcu_req.wrq);  // Strobes while busy dropped
  assign access_done = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);
  assign wake_abort  = snes_dead & cpu_clk_level;
  assign slot_ok     = evt.free_slot | snes_dead;
  assign in_addr     = (state == ST_MCU_RD_ADDR) || (state == ST_MCU_WR_ADDR);

  ////////////////////////////////////////////////////////////////////////////
  // Request latch
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (req_ok) begin
      rd_pend <= mcu_req.rrq;   // Read wins over write
      wr_pend <= ~mcu_req.rrq;
      mcu_rdy <= 1'b0;
    end else if (access_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ok) begin
      mcu_addr_q  <= mcu_req.addr;
      mcu_wdata_q <= mcu_req.wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Slot scheduling
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      delay_q <= '0;
    end else if (wake_abort) begin
      state <= ST_IDLE;  // Pending access restarts in a later slot
    end else begin
      case (state)
        ST_IDLE: begin
          if (slot_ok) begin
            if (rd_pend) begin
              state   <= ST_MCU_RD_ADDR;
              delay_q <= DLY_RELOAD;
            end else if (wr_pend) begin
              state   <= ST_MCU_WR_ADDR;
              delay_q <= DLY_RELOAD;
            end
          end
        end
        ST_MCU_RD_ADDR,
        ST_MCU_WR_ADDR: begin
          delay_q <= delay_q - 1'b1;
          if (delay_q == '0) begin
            state <= (state == ST_MCU_RD_ADDR) ? ST_MCU_RD_END : ST_MCU_WR_END;
          end
        end
        default: state <= ST_IDLE;  // Both end states
      endcase
    end
  end

  // MCU must wait for ready
  a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !mcu_rdy |-> !(mcu_req.rrq || mcu_req.wrq));

  a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot(state));

  a_addr_len: assert property (@(posedge clk) disable iff (!rst_n)
    not (in_addr [*9]));

endmodule

// File: rom_port_mux.sv
`timescale 1ns/100ps

module rom_port_mux
  import snes_bus_pkg::*;
  import mem_access_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  arb_state_t state,
  input  snes_addr_t mcu_addr_q,
  input  byte_t      mcu_wdata_q,
  input  snes_bus_t  bus,
  input  rom_data_t  rom_data_in,
  output rom_port_t  rom,
  output byte_t      mcu_din,
  output byte_t      snes_data_out,
  output logic       snes_databus_oe
);

  logic       mcu_sel;
  logic       wr_sel;
  logic       lane_lo;
  snes_addr_t eff_addr;
  byte_t      rd_lane;

  assign mcu_sel  = (state == ST_MCU_RD_ADDR) || (state == ST_MCU_WR_ADDR);
  assign wr_sel   = (state == ST_MCU_WR_ADDR);
  assign eff_addr = mcu_sel ? mcu_addr_q : bus.addr;
  assign lane_lo  = eff_addr[0];  // Odd byte on the low lane
  assign rd_lane  = lane_lo ? rom_data_in[7:0] : rom_data_in[15:8];

  ////////////////////////////////////////////////////////////////////////////
  // ROM pins
  ////////////////////////////////////////////////////////////////////////////
  assign rom.addr    = eff_addr[$bits(snes_addr_t)-1:1];
  assign rom.wdata   = lane_lo ? {8'h00, mcu_wdata_q} : {mcu_wdata_q, 8'h00};
  assign rom.data_oe = wr_sel;
  assign rom.we_n    = ~wr_sel;
  assign rom.bhe_n   = lane_lo;
  assign rom.ble_n   = ~lane_lo;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mcu_din <= '0;
    end else if (state == ST_MCU_RD_ADDR) begin
      mcu_din <= rd_lane;  // Last sample of the slot is kept
    end
  end

  // Console side
  assign snes_data_out   = rd_lane;
  assign snes_databus_oe = bus.read | bus.romsel;  // Low only for a ROM read

  a_no_write_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    (state inside {ST_MCU_RD_ADDR, ST_MCU_RD_END}) |-> (rom.we_n && !rom.data_oe));

endmodule

// File: snes_bus_pkg.sv
`include "snes_mcu_bridge_consts.svh"

package snes_bus_pkg;

  typedef logic [`SNES_ADDR_W-1:0] snes_addr_t;
  typedef logic [`BYTE_W-1:0]      byte_t;

  // Filtered console bus, control levels active low
  typedef struct packed {
    snes_addr_t addr;
    byte_t      data;
    logic       read;
    logic       write;
    logic       romsel;
    logic       cpu_clk;
  } snes_bus_t;

  // Single-cycle event strobes
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;  // cpu_clk rising
    logic cycle_end;    // cpu_clk falling
    logic free_slot;    // ROM idle for the console
  } snes_evt_t;

endpackage

// File: snes_bus_sync.sv
`timescale 1ns/100ps
`include "snes_mcu_bridge_consts.svh"

module snes_bus_sync
  import snes_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  snes_addr_t snes_addr,
  input  byte_t      snes_data,
  input  logic       snes_read,
  input  logic       snes_write,
  input  logic       snes_romsel,
  input  logic       snes_cpu_clk,
  output snes_bus_t  bus,
  output snes_evt_t  evt
);

  localparam int TOP       = `FILTER_DEPTH - 1;
  localparam int ADDR_TAPS = 7;
  localparam int DATA_TAPS = 4;
  localparam int SEL_TAPS  = 6;

  logic [TOP:0]          read_hist;
  logic [TOP:0]          write_hist;
  logic [TOP:0]          clk_hist;
  logic [SEL_TAPS-1:0]   romsel_hist;
  snes_addr_t [ADDR_TAPS-1:0] addr_hist;
  byte_t [DATA_TAPS-1:0] data_hist;

  logic free_strobe;
  logic rom_hit;
  logic cycle_start;
  logic cycle_end;

  ////////////////////////////////////////////////////////////////////////////
  // Input history
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_hist   <= '1;  // Bus idle
      write_hist  <= '1;
      romsel_hist <= '1;
      clk_hist    <= '0;
      free_strobe <= 1'b0;
    end else begin
      read_hist   <= {read_hist[TOP-1:0], snes_read};
      write_hist  <= {write_hist[TOP-1:0], snes_write};
      romsel_hist <= {romsel_hist[SEL_TAPS-2:0], snes_romsel};
      clk_hist    <= {clk_hist[TOP-1:0], snes_cpu_clk};
      // Slot after cycle start when ROM is not addressed
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  always_ff @(posedge clk) begin
    addr_hist <= {addr_hist[ADDR_TAPS-2:0], snes_addr};
    data_hist <= {data_hist[DATA_TAPS-2:0], snes_data};
  end

  // Levels as AND of two taps
  assign bus.addr    = addr_hist[ADDR_TAPS-1] & addr_hist[ADDR_TAPS-2];
  assign bus.data    = data_hist[DATA_TAPS-1] & data_hist[DATA_TAPS-2];
  assign bus.read    = read_hist[2] & read_hist[1];
  assign bus.write   = write_hist[2] & write_hist[1];
  assign bus.romsel  = romsel_hist[SEL_TAPS-1] & romsel_hist[SEL_TAPS-2];
  assign bus.cpu_clk = clk_hist[2] & clk_hist[1];

  assign rom_hit = ~bus.romsel;  // No mapper, ROMSEL alone decides

  ////////////////////////////////////////////////////////////////////////////
  // Edge patterns across adjacent taps
  ////////////////////////////////////////////////////////////////////////////
  assign cycle_start = ((clk_hist[TOP:2] & clk_hist[TOP-1:1]) == 6'b000011);
  assign cycle_end   = ((clk_hist[TOP:2] | clk_hist[TOP-1:1]) == 6'b111000);

  assign evt.rd_start    = ((read_hist[TOP-1:1] | read_hist[TOP:2]) == 6'b111100);
  assign evt.rd_end      = ((read_hist[TOP-1:1] & read_hist[TOP:2]) == 6'b000001);
  assign evt.wr_end      = ((write_hist[TOP-1:1] & write_hist[TOP:2]) == 6'b000001);
  assign evt.cycle_start = cycle_start;
  assign evt.cycle_end   = cycle_end;
  assign evt.free_slot   = cycle_end | free_strobe;

endmodule

// File: snes_liveness_timer.sv
`timescale 1ns/100ps
`include "snes_mcu_bridge_consts.svh"

module snes_liveness_timer #(
  parameter int DEAD_TIMEOUT = `SNES_DEAD_TIMEOUT
) (
  input  logic clk,
  input  logic rst_n,
  input  logic cpu_clk_level,
  output logic snes_dead,
  output logic snes_reset_strobe
);

  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);
  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(DEAD_TIMEOUT);

  logic [CNT_W-1:0] low_cnt;  // Cycles with console clock low

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      low_cnt           <= '0;
      snes_dead         <= 1'b1;  // Console presumed off at power-up
      snes_reset_strobe <= 1'b0;
    end else begin
      snes_reset_strobe <= 1'b0;
      if (cpu_clk_level) begin
        low_cnt   <= '0;
        snes_dead <= 1'b0;
        // Wake-up pulse
        snes_reset_strobe <= snes_dead;
      end else begin
        if (low_cnt <= LIMIT) begin
          low_cnt <= low_cnt + 1'b1;  // Holds just past the limit
        end
        if (low_cnt > LIMIT) begin
          snes_dead <= 1'b1;
        end
      end
    end
  end

endmodule

// File: snes_mcu_bridge.f
+incdir+.
snes_bus_pkg.sv
mem_access_pkg.sv
snes_bus_sync.sv
snes_liveness_timer.sv
rom_arbiter_fsm.sv
rom_port_mux.sv
snes_mcu_bridge.sv
bridge_checker.sv
tb_snes_mcu_bridge.sv

// File: snes_mcu_bridge.sv
`timescale 1ns/100ps
`include "snes_mcu_bridge_consts.svh"

module snes_mcu_bridge
  import snes_bus_pkg::*;
  import mem_access_pkg::*;
#(
  parameter int DEAD_TIMEOUT = `SNES_DEAD_TIMEOUT
) (
  input  logic       clk2,
  input  logic       rst_n,
  // Console pins
  input  snes_addr_t snes_addr,
  input  byte_t      snes_data,
  input  logic       snes_read,
  input  logic       snes_write,
  input  logic       snes_romsel,
  input  logic       snes_cpu_clk,
  output byte_t      snes_data_out,
  output logic       snes_databus_oe,
  output logic       snes_reset_strobe,
  // MCU side
  input  mcu_req_t   mcu_req,
  output byte_t      mcu_din,
  output logic       mcu_rdy,
  // ROM/PSRAM
  input  rom_data_t  rom_data_in,
  output rom_port_t  rom
);

  snes_bus_t  bus;
  snes_evt_t  evt;
  logic       snes_dead;
  arb_state_t state;
  snes_addr_t mcu_addr_q;
  byte_t      mcu_wdata_q;

  snes_bus_sync u_sync (
    .clk          (clk2),
    .rst_n        (rst_n),
    .snes_addr    (snes_addr),
    .snes_data    (snes_data),
    .snes_read    (snes_read),
    .snes_write   (snes_write),
    .snes_romsel  (snes_romsel),
    .snes_cpu_clk (snes_cpu_clk),
    .bus          (bus),
    .evt          (evt)
  );

  snes_liveness_timer #(
    .DEAD_TIMEOUT (DEAD_TIMEOUT)
  ) u_live (
    .clk               (clk2),
    .rst_n             (rst_n),
    .cpu_clk_level     (bus.cpu_clk),
    .snes_dead         (snes_dead),
    .snes_reset_strobe (snes_reset_strobe)
  );

  rom_arbiter_fsm u_arb (
    .clk           (clk2),
    .rst_n         (rst_n),
    .mcu_req       (mcu_req),
    .evt           (evt),
    .snes_dead     (snes_dead),
    .cpu_clk_level (bus.cpu_clk),
    .state         (state),
    .mcu_addr_q    (mcu_addr_q),
    .mcu_wdata_q   (mcu_wdata_q),
    .mcu_rdy       (mcu_rdy)
  );

  rom_port_mux u_mux (
    .clk             (clk2),
    .rst_n           (rst_n),
    .state           (state),
    .mcu_addr_q      (mcu_addr_q),
    .mcu_wdata_q     (mcu_wdata_q),
    .bus             (bus),
    .rom_data_in     (rom_data_in),
    .rom             (rom),
    .mcu_din         (mcu_din),
    .snes_data_out   (snes_data_out),
    .snes_databus_oe (snes_databus_oe)
  );

endmodule

// File: snes_mcu_bridge_consts.svh
`ifndef SNES_MCU_BRIDGE_CONSTS_SVH
`define SNES_MCU_BRIDGE_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////
`define SNES_ADDR_W 24   // Console address bus
`define ROM_WORD_W  23   // 16-bit ROM word address
`define ROM_DATA_W  16
`define BYTE_W      8

// Input history length per console control line
`define FILTER_DEPTH 8

////////////////////////////////////////////////////////////////////////////
// Timing
////////////////////////////////////////////////////////////////////////////
`define ROM_CYCLE_LEN 7          // Countdown reload, 8 cycles on the bus
`define SNES_DEAD_TIMEOUT 86400  // About 1 ms of stopped console clock

`endif

// File: snes_mcu_bridge_testdata.txt
# op byte_addr wdata result cycles
# ops: mrd mwr crd slp wak, numbers in hex, cycles 0 means latency not checked
mrd 000010 00 08 0b
mrd 000011 00 f7 0b
mrd 123456 00 38 0b
mrd 0001fd 00 01 0b
mwr 000021 a5 00 0b
mrd 000021 00 a5 0b
mrd 000020 00 10 0b
mwr 000040 3c 00 0b
mrd 000040 00 3c 0b
mrd 000041 00 df 0b
mwr 0abcde 77 00 0b
mrd 0abcdf 00 cb 0b
mrd 0abcde 00 77 0b
wak 000000 00 01 00
crd 000030 00 18 00
crd 000031 00 e7 00
crd 000021 00 a5 00
crd 0abcde 00 77 00
mrd 000050 00 28 00
mrd 000011 00 f7 00
mwr 000061 c3 00 00
mrd 000061 00 c3 00
mrd 000060 00 30 00
crd 000061 00 c3 00
slp 000000 00 00 00
mrd 000070 00 38 0b
wak 000000 00 01 00
mrd 000071 00 c7 00

// File: tb_snes_mcu_bridge.sv
`timescale 1ns/100ps
`include "snes_mcu_bridge_consts.svh"

module tb_snes_mcu_bridge
  import snes_bus_pkg::*;
  import mem_access_pkg::*;
();

  localparam int PERIOD          = 40;
  localparam int DRIVE_DLY       = 2;
  localparam int RESET_CYCLES    = 8;
  localparam int TB_DEAD_TIMEOUT = 200;
  localparam int CYCLES_PER_LINE = 400;
  localparam int CPU_HALF        = 6;   // CLK2 cycles per console clock phase
  localparam int CONSOLE_SETTLE  = 16;  // Covers the input filter lag
  localparam int WAKE_WAIT       = 32;

  localparam logic [4:0] CHK_RESET   = 5'b00001;
  localparam logic [4:0] CHK_DIN     = 5'b00010;
  localparam logic [4:0] CHK_LAT     = 5'b00100;
  localparam logic [4:0] CHK_CONSOLE = 5'b01000;
  localparam logic [4:0] CHK_STROBES = 5'b10000;

  // One line of the data file
  typedef struct packed {
    logic [23:0] kind;
    snes_addr_t  addr;
    byte_t       wdata;
    byte_t       result;
    byte_t       cycles;  // Expected latency, 0 when not checked
  } test_op_t;

  logic       clk2 = 1'b0;
  logic       rst_n;
  snes_addr_t snes_addr;
  byte_t      snes_data;
  logic       snes_read;
  logic       snes_write;
  logic       snes_romsel;
  logic       snes_cpu_clk = 1'b0;
  mcu_req_t   mcu_req;
  rom_data_t  rom_data_in = '0;
  byte_t      snes_data_out;
  logic       snes_databus_oe;
  logic       snes_reset_strobe;
  byte_t      mcu_din;
  logic       mcu_rdy;
  rom_port_t  rom;

  logic [4:0] chk_sel;
  byte_t      exp_value;
  int         chk_errors;
  int         tb_errors;
  int         cycle_cnt = 0;
  int         cycle_limit;
  logic       console_run;
  logic       run_now;
  int         phase = 0;
  test_op_t   tests[$];
  rom_data_t  written [rom_word_t];  // Words changed by writes

  always #(PERIOD/2) clk2 = ~clk2;

  snes_mcu_bridge #(
    .DEAD_TIMEOUT (TB_DEAD_TIMEOUT)
  ) uut (
    .clk2              (clk2),
    .rst_n             (rst_n),
    .snes_addr         (snes_addr),
    .snes_data         (snes_data),
    .snes_read         (snes_read),
    .snes_write        (snes_write),
    .snes_romsel       (snes_romsel),
    .snes_cpu_clk      (snes_cpu_clk),
    .snes_data_out     (snes_data_out),
    .snes_databus_oe   (snes_databus_oe),
    .snes_reset_strobe (snes_reset_strobe),
    .mcu_req           (mcu_req),
    .mcu_din           (mcu_din),
    .mcu_rdy           (mcu_rdy),
    .rom_data_in       (rom_data_in),
    .rom               (rom)
  );

  bridge_checker u_checker (
    .clk               (clk2),
    .rst_n             (rst_n),
    .mcu_req           (mcu_req),
    .mcu_rdy           (mcu_rdy),
    .mcu_din           (mcu_din),
    .snes_data_out     (snes_data_out),
    .snes_databus_oe   (snes_databus_oe),
    .snes_reset_strobe (snes_reset_strobe),
    .rom               (rom),
    .chk_reset         (chk_sel[0]),
    .chk_din           (chk_sel[1]),
    .chk_lat           (chk_sel[2]),
    .chk_console       (chk_sel[3]),
    .chk_strobes       (chk_sel[4]),
    .exp_value         (exp_value),
    .errors            (chk_errors)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM model, 16-bit words with byte lanes
  ////////////////////////////////////////////////////////////////////////////
  function automatic rom_data_t fill_word(input rom_word_t a);
    byte_t hi;
    hi = a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]};  // Low byte for small addresses
    return {hi, ~hi};
  endfunction

  always @(negedge clk2) begin : psram
    rom_data_t cur;
    if ($isunknown(rom.addr)) begin
      rom_data_in <= '0;  // Filter still filling
    end else begin
      cur = written.exists(rom.addr) ? written[rom.addr] : fill_word(rom.addr);
      if (!rom.we_n && rom.data_oe) begin  // Data only when the FPGA drives the bus
        if (!rom.bhe_n) cur[15:8] = rom.wdata[15:8];
        if (!rom.ble_n) cur[7:0] = rom.wdata[7:0];
        written[rom.addr] = cur;
      end
      rom_data_in <= cur;
    end
  end

  // Console clock, run flag taken at the edge
  always @(posedge clk2) begin
    run_now = console_run;
    #DRIVE_DLY;
    if (!run_now) begin
      phase        = 0;
      snes_cpu_clk = 1'b0;
    end else begin
      phase        = (phase + 1) % (2 * CPU_HALF);
      snes_cpu_clk = (phase >= CPU_HALF);
    end
  end

  task automatic report_counts();
    $display("Done: %0d test lines, %0d check errors, %0d other errors",
             tests.size(), chk_errors, tb_errors);
  endtask

  always @(posedge clk2) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      tb_errors++;
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      report_counts();
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all entered 2 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk2);
      #DRIVE_DLY;
    end
  endtask

  task automatic request_check(input logic [4:0] sel, input byte_t value);
    chk_sel   = sel;
    exp_value = value;
    wait_cycles(1);
    chk_sel   = '0;
  endtask

  task automatic mcu_access(input logic is_write, input test_op_t op);
    int waited;
    while (!mcu_rdy) wait_cycles(1);
    mcu_req.rrq   = ~is_write;
    mcu_req.wrq   = is_write;
    mcu_req.addr  = op.addr;
    mcu_req.wdata = op.wdata;
    wait_cycles(1);
    mcu_req.rrq = 1'b0;
    mcu_req.wrq = 1'b0;
    waited = 1;
    while (!mcu_rdy && waited < CYCLES_PER_LINE) begin  // Ready marks the end
      wait_cycles(1);
      waited++;
    end
    if (!mcu_rdy) begin
      tb_errors++;
      $display("MCU access to 0x%0h not finished after %0d cycles", op.addr, waited);
    end else begin
      if (!is_write) request_check(CHK_DIN, op.result);
      if (op.cycles != 8'h00) request_check(CHK_LAT, op.cycles);
    end
  endtask

  // Bus stays parked on the ROM read afterwards
  task automatic console_read(input test_op_t op);
    snes_addr   = op.addr;
    snes_romsel = 1'b0;
    snes_read   = 1'b0;
    wait_cycles(CONSOLE_SETTLE);
    request_check(CHK_CONSOLE, op.result);
  endtask

  task automatic console_sleep(input test_op_t op);
    snes_read   = 1'b1;
    snes_romsel = 1'b1;
    console_run = 1'b0;
    wait_cycles(TB_DEAD_TIMEOUT + WAKE_WAIT);
    request_check(CHK_STROBES, op.result);
  endtask

  task automatic console_wake(input test_op_t op);
    console_run = 1'b1;
    wait_cycles(WAKE_WAIT);
    request_check(CHK_STROBES, op.result);
  endtask

  task automatic run_line(input test_op_t op, input int line_no);
    case (op.kind)
      "mrd":   mcu_access(1'b0, op);
      "mwr":   mcu_access(1'b1, op);
      "crd":   console_read(op);
      "slp":   console_sleep(op);
      "wak":   console_wake(op);
      default: begin
        tb_errors++;
        $display("Unknown operation in test line %0d", line_no);
      end
    endcase
  endtask

  task automatic load_tests();
    integer fd;
    int n;
    logic [8*128-1:0] text;
    logic [23:0] kind;
    snes_addr_t addr;
    byte_t wdata;
    byte_t result;
    byte_t cycles;
    fd = $fopen("snes_mcu_bridge_testdata.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("Could not open the test data file");
      return;
    end
    while (!$feof(fd)) begin
      text = '0;
      n = $fgets(text, fd);
      if (n == 0) break;
      n = $sscanf(text, "%s %h %h %h %h", kind, addr, wdata, result, cycles);
      if (n == 5) tests.push_back({kind, addr, wdata, result, cycles});  // Comments skipped
    end
    $fclose(fd);
  endtask

  initial begin
    rst_n       = 1'b0;
    snes_addr   = '0;
    snes_data   = '0;
    snes_read   = 1'b1;
    snes_write  = 1'b1;
    snes_romsel = 1'b1;
    mcu_req     = '0;
    console_run = 1'b0;  // Console off at power-up
    chk_sel     = '0;
    exp_value   = '0;
    tb_errors   = 0;
    load_tests();
    if (tests.size() == 0) begin
      tb_errors++;
      $display("No test lines were read");
    end
    cycle_limit = CYCLES_PER_LINE * tests.size() + TB_DEAD_TIMEOUT + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk2);
    #DRIVE_DLY;
    rst_n = 1'b1;
    request_check(CHK_RESET, 8'h00);

    foreach (tests[i]) run_line(tests[i], i + 1);
    wait_cycles(2);

    report_counts();
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
